//--- hw/agg_pkg.sv
/* field layout shared by the aggregation engine.
   one edge per 64-bit bus word; lane arithmetic wraps at 32 bits */
package agg_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word
  ////////////////////////////////////////////////////////////
  localparam int INST_W = 128;

  // feature base in the input buffer
  localparam int INPUT_START_LSB      = 32;
  localparam int INPUT_START_W        = 16;
  // feature words per node
  localparam int ADDR_PER_FEATURE_LSB = 48;
  localparam int ADDR_PER_FEATURE_W   = 16;
  // feature base in the output buffer
  localparam int OUTPUT_START_LSB     = 64;
  localparam int OUTPUT_START_W       = 16;
  // edge list position in DRAM, in bus words
  localparam int EDGE_DRAM_START_LSB  = 96;
  localparam int EDGE_DRAM_START_W    = 16;
  localparam int EDGE_NUMBER_LSB      = 112;
  localparam int EDGE_NUMBER_W        = 16;

  ////////////////////////////////////////////////////////////
  // edge word
  ////////////////////////////////////////////////////////////
  localparam int EDGE_W = 64;

  localparam int SRC_NODE_LSB   = 0;
  localparam int SRC_NODE_W     = 15;
  // set on the first edge into a destination, restarts the sum
  localparam int FIRST_FLAG_BIT = 15;
  localparam int DST_NODE_LSB   = 16;
  localparam int DST_NODE_W     = 15;
  localparam int WEIGHT_LSB     = 32;
  localparam int WEIGHT_W       = 32;

  ////////////////////////////////////////////////////////////
  // lanes and address spaces
  ////////////////////////////////////////////////////////////
  localparam int LANE_W      = 32;
  localparam int BUF_ADDR_W  = 11;
  // word address on the edge bus
  localparam int DRAM_ADDR_W = 32;

endpackage

//--- hw/edge_fetch_wb.sv
/* single-word wishbone classic reads, one request outstanding at a time.
   fetch_start and fetch_next may share a cycle; the request then uses fetch_base */
`timescale 1ns/1ps

module edge_fetch_wb
  import agg_pkg::*;
(
  input  logic                   kernel_rst,
  input  logic                   kernel_clk,
  input  logic                   fetch_start,
  input  logic [DRAM_ADDR_W-1:0] fetch_base,
  input  logic                   fetch_next,
  output logic                   edge_valid,
  output logic [EDGE_W-1:0]      edge_data,
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [DRAM_ADDR_W-1:0] wb_adr,
  input  logic [EDGE_W-1:0]      wb_dat_i,
  input  logic                   wb_ack
);

  typedef enum logic {
    F_IDLE,
    F_BUS
  } fetch_state_t;

  fetch_state_t           state;
  logic [DRAM_ADDR_W-1:0] word_ptr;
  logic [DRAM_ADDR_W-1:0] req_addr;

  // a fresh base overrides the running pointer
  assign req_addr = fetch_start ? fetch_base : word_ptr;

  // cyc and stb rise and fall together, read only
  assign wb_cyc = (state == F_BUS);
  assign wb_stb = (state == F_BUS);
  assign wb_we  = 1'b0;

  ////////////////////////////////////////////////////////////
  // bus state and word pointer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      state      <= F_IDLE;
      word_ptr   <= '0;
      edge_valid <= 1'b0;
    end else begin
      edge_valid <= 1'b0;
      if (fetch_start) begin
        word_ptr <= fetch_base;
      end
      case (state)
        F_IDLE: begin
          if (fetch_next) begin
            state    <= F_BUS;
            word_ptr <= req_addr + 1'b1;
          end
        end
        F_BUS: begin
          // drop the cycle right after ack
          if (wb_ack) begin
            state      <= F_IDLE;
            edge_valid <= 1'b1;
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  // address held for the whole cycle, data kept until the next ack
  always_ff @(posedge kernel_rst) begin
    if (state == F_IDLE && fetch_next) begin
      wb_adr <= req_addr;
    end
    if (state == F_BUS && wb_ack) begin
      edge_data <= wb_dat_i;
    end
  end

endmodule

//--- hw/agg_sequencer.sv
/* walks the edge list of one instruction; ap_start is dropped while busy.
   a run with no edges or no feature words finishes at once without bus traffic */
`timescale 1ns/1ps

module agg_sequencer
  import agg_pkg::*;
(
  input  logic                   kernel_rst,
  input  logic                   kernel_clk,
  input  logic                   ap_start,
  input  logic [INST_W-1:0]      ctrl_instruction,
  input  logic [DRAM_ADDR_W-1:0] ctrl_addr_offset,
  output logic                   ap_done,
  output logic                   fetch_start,
  output logic [DRAM_ADDR_W-1:0] fetch_base,
  output logic                   fetch_next,
  input  logic                   edge_valid,
  input  logic [EDGE_W-1:0]      edge_data,
  output logic                   beat_valid,
  output logic                   beat_first,
  output logic                   beat_last,
  output logic [BUF_ADDR_W-1:0]  beat_in_addr,
  output logic [BUF_ADDR_W-1:0]  beat_out_addr,
  output logic [LANE_W-1:0]      beat_weight,
  input  logic                   edge_drained
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_ISSUE,
    S_DRAIN
  } seq_state_t;

  seq_state_t state;
  logic       launch;
  logic       accept;
  logic       last_beat;

  // latched instruction
  logic [INPUT_START_W-1:0]      input_start;
  logic [ADDR_PER_FEATURE_W-1:0] addr_per_feature;
  logic [OUTPUT_START_W-1:0]     output_start;
  logic [EDGE_DRAM_START_W-1:0]  edge_start;
  logic [EDGE_NUMBER_W-1:0]      edge_number;
  logic [DRAM_ADDR_W-1:0]        dram_offset;

  // current edge
  logic [ADDR_PER_FEATURE_W-1:0] in_base;
  logic [ADDR_PER_FEATURE_W-1:0] out_base;
  logic [WEIGHT_W-1:0]           edge_weight;
  logic                          edge_first;

  logic [ADDR_PER_FEATURE_W-1:0] beat_cnt;
  logic [EDGE_NUMBER_W-1:0]      edge_cnt;

  assign accept    = ap_start && (state == S_IDLE) && !launch;
  assign last_beat = (beat_cnt == addr_per_feature - 1'b1);

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      state       <= S_IDLE;
      launch      <= 1'b0;
      fetch_start <= 1'b0;
      fetch_next  <= 1'b0;
      ap_done     <= 1'b0;
      beat_valid  <= 1'b0;
      beat_cnt    <= '0;
      edge_cnt    <= '0;
    end else begin
      launch      <= accept;
      fetch_start <= 1'b0;
      fetch_next  <= 1'b0;
      ap_done     <= 1'b0;
      beat_valid  <= 1'b0;
      case (state)
        S_IDLE: begin
          // second cycle after start, base is being formed
          if (launch) begin
            if (edge_number == '0 || addr_per_feature == '0) begin
              ap_done <= 1'b1;
            end else begin
              fetch_start <= 1'b1;
              fetch_next  <= 1'b1;
              edge_cnt    <= '0;
              state       <= S_FETCH;
            end
          end
        end
        S_FETCH: begin
          if (edge_valid) begin
            beat_cnt <= '0;
            state    <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          beat_valid <= 1'b1;
          if (last_beat) begin
            state <= S_DRAIN;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        S_DRAIN: begin
          // wait out the pipeline so the next edge reads settled data
          if (edge_drained) begin
            if (edge_cnt == edge_number - 1'b1) begin
              ap_done <= 1'b1;
              state   <= S_IDLE;
            end else begin
              edge_cnt   <= edge_cnt + 1'b1;
              fetch_next <= 1'b1;
              state      <= S_FETCH;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction fields, edge decode, beat addresses
  ////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst) begin
    if (accept) begin
      input_start      <= ctrl_instruction[INPUT_START_LSB +: INPUT_START_W];
      addr_per_feature <= ctrl_instruction[ADDR_PER_FEATURE_LSB +: ADDR_PER_FEATURE_W];
      output_start     <= ctrl_instruction[OUTPUT_START_LSB +: OUTPUT_START_W];
      edge_start       <= ctrl_instruction[EDGE_DRAM_START_LSB +: EDGE_DRAM_START_W];
      edge_number      <= ctrl_instruction[EDGE_NUMBER_LSB +: EDGE_NUMBER_W];
      dram_offset      <= ctrl_addr_offset;
    end
    if (launch) begin
      fetch_base <= dram_offset + DRAM_ADDR_W'(edge_start);
    end
    // node bases once per edge, keeps the multiply off the beat path
    if (state == S_FETCH && edge_valid) begin
      in_base     <= input_start + addr_per_feature * edge_data[SRC_NODE_LSB +: SRC_NODE_W];
      out_base    <= output_start + addr_per_feature * edge_data[DST_NODE_LSB +: DST_NODE_W];
      edge_weight <= edge_data[WEIGHT_LSB +: WEIGHT_W];
      edge_first  <= edge_data[FIRST_FLAG_BIT];
    end
    if (state == S_ISSUE) begin
      beat_in_addr  <= BUF_ADDR_W'(in_base + beat_cnt);
      beat_out_addr <= BUF_ADDR_W'(out_base + beat_cnt);
      beat_first    <= edge_first;
      beat_last     <= last_beat;
      beat_weight   <= edge_weight;
    end
  end

endmodule

//--- hw/feature_mac.sv
/* fixed multiply-add pipeline, no back-pressure; write lands BUF_RD_LATENCY+3 after a beat.
   BUF_RD_LATENCY must be at least 1 */
`timescale 1ns/1ps

module feature_mac
  import agg_pkg::*;
#(
  parameter int LANES          = 4,
  parameter int BUF_RD_LATENCY = 2
) (
  input  logic                    kernel_rst,
  input  logic                    kernel_clk,
  input  logic                    beat_valid,
  input  logic                    beat_first,
  input  logic                    beat_last,
  input  logic [BUF_ADDR_W-1:0]   beat_in_addr,
  input  logic [BUF_ADDR_W-1:0]   beat_out_addr,
  input  logic [LANE_W-1:0]       beat_weight,
  output logic                    in_rd_en,
  output logic [BUF_ADDR_W-1:0]   in_rd_addr,
  input  logic [LANES*LANE_W-1:0] in_rd_data,
  output logic                    out_rd_en,
  output logic [BUF_ADDR_W-1:0]   out_rd_addr,
  input  logic [LANES*LANE_W-1:0] out_rd_data,
  output logic                    out_wr_en,
  output logic [BUF_ADDR_W-1:0]   out_wr_addr,
  output logic [LANES*LANE_W-1:0] out_wr_data,
  output logic                    edge_drained
);

  localparam int L = BUF_RD_LATENCY;

  // stage 0 is the read request, stage L lines up with read data
  logic [L:0]            dl_valid;
  logic [L:0]            dl_first;
  logic [L:0]            dl_last;
  logic [BUF_ADDR_W-1:0] dl_addr [L+1];
  logic [LANE_W-1:0]     dl_weight [L+1];

  // multiply stage
  logic                    mul_valid;
  logic                    mul_first;
  logic                    mul_last;
  logic [BUF_ADDR_W-1:0]   mul_addr;
  logic [LANES*LANE_W-1:0] mul_prod;
  logic [LANES*LANE_W-1:0] mul_dst;

  // both buffers are read by the same request
  assign in_rd_en    = dl_valid[0];
  assign out_rd_en   = dl_valid[0];
  assign out_rd_addr = dl_addr[0];

  ////////////////////////////////////////////////////////////
  // valid flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      dl_valid     <= '0;
      mul_valid    <= 1'b0;
      out_wr_en    <= 1'b0;
      edge_drained <= 1'b0;
    end else begin
      dl_valid     <= {dl_valid[L-1:0], beat_valid};
      mul_valid    <= dl_valid[L];
      out_wr_en    <= mul_valid;
      edge_drained <= mul_valid && mul_last;
    end
  end

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////
  always_ff @(posedge kernel_rst) begin
    in_rd_addr   <= beat_in_addr;
    dl_first     <= {dl_first[L-1:0], beat_first};
    dl_last      <= {dl_last[L-1:0], beat_last};
    dl_addr[0]   <= beat_out_addr;
    dl_weight[0] <= beat_weight;
    for (int k = 1; k <= L; k++) begin
      dl_addr[k]   <= dl_addr[k-1];
      dl_weight[k] <= dl_weight[k-1];
    end

    // products wrap to the lane width
    for (int i = 0; i < LANES; i++) begin
      mul_prod[i*LANE_W +: LANE_W] <= in_rd_data[i*LANE_W +: LANE_W] * dl_weight[L];
    end
    mul_dst   <= out_rd_data;
    mul_first <= dl_first[L];
    mul_last  <= dl_last[L];
    mul_addr  <= dl_addr[L];

    // first edge of a destination starts from zero
    for (int i = 0; i < LANES; i++) begin
      out_wr_data[i*LANE_W +: LANE_W] <= mul_prod[i*LANE_W +: LANE_W]
                                         + (mul_first ? '0 : mul_dst[i*LANE_W +: LANE_W]);
    end
    out_wr_addr <= mul_addr;
  end

endmodule

//--- hw/agg_top.sv
/* aggregation engine top: edge fetch over wishbone classic, feature mac on the buffers.
   buffers must return read data exactly BUF_RD_LATENCY cycles after the enable */
`timescale 1ns/1ps

module agg_top
  import agg_pkg::*;
#(
  parameter int LANES          = 4,
  parameter int BUF_RD_LATENCY = 2
) (
  input  logic                      kernel_rst,
  input  logic                      kernel_clk,
  // control
  input  logic                      ap_start,
  input  logic [INST_W-1:0]         ctrl_instruction,
  input  logic [DRAM_ADDR_W-1:0]    ctrl_addr_offset,
  output logic                      ap_done,
  // wishbone classic read master
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic                      wb_we,
  output logic [DRAM_ADDR_W-1:0]    wb_adr,
  input  logic [EDGE_W-1:0]         wb_dat_i,
  input  logic                      wb_ack,
  // input buffer read
  output logic                      in_rd_en,
  output logic [BUF_ADDR_W-1:0]     in_rd_addr,
  input  logic [LANES*LANE_W-1:0]   in_rd_data,
  // output buffer read and write
  output logic                      out_rd_en,
  output logic [BUF_ADDR_W-1:0]     out_rd_addr,
  input  logic [LANES*LANE_W-1:0]   out_rd_data,
  output logic                      out_wr_en,
  output logic [BUF_ADDR_W-1:0]     out_wr_addr,
  output logic [LANES*LANE_W-1:0]   out_wr_data
);

  // sequencer to fetcher
  logic                   fetch_start;
  logic [DRAM_ADDR_W-1:0] fetch_base;
  logic                   fetch_next;
  logic                   edge_valid;
  logic [EDGE_W-1:0]      edge_data;

  // sequencer to mac
  logic                   beat_valid;
  logic                   beat_first;
  logic                   beat_last;
  logic [BUF_ADDR_W-1:0]  beat_in_addr;
  logic [BUF_ADDR_W-1:0]  beat_out_addr;
  logic [LANE_W-1:0]      beat_weight;
  logic                   edge_drained;

  agg_sequencer u_sequencer (
    .kernel_rst (kernel_rst), .kernel_clk (kernel_clk),
    .ap_start (ap_start), .ctrl_instruction (ctrl_instruction),
    .ctrl_addr_offset (ctrl_addr_offset), .ap_done (ap_done),
    .fetch_start (fetch_start), .fetch_base (fetch_base), .fetch_next (fetch_next),
    .edge_valid (edge_valid), .edge_data (edge_data),
    .beat_valid (beat_valid), .beat_first (beat_first), .beat_last (beat_last),
    .beat_in_addr (beat_in_addr), .beat_out_addr (beat_out_addr),
    .beat_weight (beat_weight), .edge_drained (edge_drained)
  );

  edge_fetch_wb u_fetch (
    .kernel_rst (kernel_rst), .kernel_clk (kernel_clk),
    .fetch_start (fetch_start), .fetch_base (fetch_base), .fetch_next (fetch_next),
    .edge_valid (edge_valid), .edge_data (edge_data),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_i (wb_dat_i), .wb_ack (wb_ack)
  );

  feature_mac #(
    .LANES (LANES), .BUF_RD_LATENCY (BUF_RD_LATENCY)
  ) u_mac (
    .kernel_rst (kernel_rst), .kernel_clk (kernel_clk),
    .beat_valid (beat_valid), .beat_first (beat_first), .beat_last (beat_last),
    .beat_in_addr (beat_in_addr), .beat_out_addr (beat_out_addr),
    .beat_weight (beat_weight),
    .in_rd_en (in_rd_en), .in_rd_addr (in_rd_addr), .in_rd_data (in_rd_data),
    .out_rd_en (out_rd_en), .out_rd_addr (out_rd_addr), .out_rd_data (out_rd_data),
    .out_wr_en (out_wr_en), .out_wr_addr (out_wr_addr), .out_wr_data (out_wr_data),
    .edge_drained (edge_drained)
  );

endmodule

//--- sim/tb_clk_gen.sv
/* free-running 10 ns clock on kernel_rst; kernel_clk is the active high reset,
   held for the first 3 rising edges */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic kernel_rst,
  output logic kernel_clk
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;

  always #5 clk_q = ~clk_q;

  // release on a rising edge, like any other driven input
  initial begin
    repeat (3) @(posedge clk_q);
    rst_q <= 1'b0;
  end

  assign kernel_rst = clk_q;
  assign kernel_clk = rst_q;

endmodule

//--- sim/agg_props.sv
/* wishbone and control rules for agg_top; failures are also counted in assert_fails */
`timescale 1ns/1ps

module agg_props
  import agg_pkg::*;
(
  input logic                   kernel_rst,
  input logic                   kernel_clk,
  input logic                   ap_start,
  input logic                   ap_done,
  input logic                   wb_cyc,
  input logic                   wb_stb,
  input logic                   wb_ack,
  input logic [DRAM_ADDR_W-1:0] wb_adr,
  input logic                   out_wr_en
);

  int   assert_fails = 0;
  logic run_active;

  // open from a start until its done
  always_ff @(posedge kernel_rst or posedge kernel_clk) begin
    if (kernel_clk) begin
      run_active <= 1'b0;
    end else if (ap_done) begin
      run_active <= 1'b0;
    end else if (ap_start) begin
      run_active <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus
  ////////////////////////////////////////////////////////////
  // stb needs cyc and is gone in the cycle after ack
  a_stb_cyc: assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    wb_stb |-> (wb_cyc && !$past(wb_ack)))
    else begin
      assert_fails++;
      $error("wishbone stb high without cyc or still high after ack");
    end

  a_adr_hold: assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
      assert_fails++;
      $error("wishbone address or stb changed before ack");
    end

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////
  a_done_pulse: assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    ap_done |=> !ap_done)
    else begin
      assert_fails++;
      $error("ap_done held longer than one cycle");
    end

  a_wr_window: assert property (@(posedge kernel_rst) disable iff (kernel_clk)
    out_wr_en |-> run_active)
    else begin
      assert_fails++;
      $error("output buffer write outside a run");
    end

endmodule

bind agg_top agg_props u_props (
  .kernel_rst (kernel_rst),
  .kernel_clk (kernel_clk),
  .ap_start   (ap_start),
  .ap_done    (ap_done),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_ack     (wb_ack),
  .wb_adr     (wb_adr),
  .out_wr_en  (out_wr_en)
);

//--- sim/agg_tb.sv
/* table-driven testbench for agg_top with dram and feature buffer models.
   buffer models return data two cycles after the enable, as the DUT expects */
`timescale 1ns/1ps

module agg_tb
  import agg_pkg::*;
();

  localparam int LANES     = 4;
  localparam int FEAT_W    = LANES * LANE_W;
  localparam int BUF_WORDS = 2 ** BUF_ADDR_W;
  localparam int NROWS     = 6;
  localparam int TIMEOUT   = 2000;
  localparam logic [31:0] IN_SALT  = 32'h1234_0000;
  localparam logic [31:0] OUT_SALT = 32'h5a5a_0000;

  // input_start, addr_per_feature, output_start, edge_start, edge_number,
  // first edge in EDGES, dram offset, random ack delay, ap_start while busy
  localparam int ROW [NROWS][9] = '{
    '{16, 1, 100,  0, 1, 0, 'h10, 0, 0},
    '{ 0, 1,  40,  4, 2, 1, 'h20, 0, 0},
    '{ 8, 3, 200,  8, 3, 3, 'h40, 0, 0},
    '{ 8, 3, 200, 20, 3, 3, 'h30, 1, 0},
    '{ 0, 2,   0,  0, 0, 0, 'h50, 0, 0},
    '{32, 2, 300,  2, 2, 6, 'h60, 1, 1}
  };
  // src node, dst node, first flag, weight
  localparam int EDGES [8][4] = '{
    '{5, 9, 1, -3}, '{2, 3, 1, 7}, '{4, 3, 0, 'h80000001}, '{1, 2, 1, 3},
    '{6, 0, 1, 11}, '{3, 2, 0, -2}, '{7, 1, 1, 'h10001}, '{0, 1, 0, 5}
  };

  logic                   kernel_rst;
  logic                   kernel_clk;
  logic                   ap_start = 1'b0;
  logic [INST_W-1:0]      ctrl_instruction = '0;
  logic [DRAM_ADDR_W-1:0] ctrl_addr_offset = '0;
  logic                   ap_done;
  logic                   wb_cyc, wb_stb, wb_we, wb_ack = 1'b0;
  logic [DRAM_ADDR_W-1:0] wb_adr;
  logic [EDGE_W-1:0]      wb_dat_i = '0;
  logic                   in_rd_en, out_rd_en, out_wr_en;
  logic [BUF_ADDR_W-1:0]  in_rd_addr, out_rd_addr, out_wr_addr;
  logic [FEAT_W-1:0]      in_rd_data = '0;
  logic [FEAT_W-1:0]      out_rd_data = '0;
  logic [FEAT_W-1:0]      out_wr_data;

  // memory models and their bookkeeping
  logic [FEAT_W-1:0]      in_mem [BUF_WORDS];
  logic [FEAT_W-1:0]      out_mem [BUF_WORDS];
  logic [FEAT_W-1:0]      exp_mem [BUF_WORDS];
  logic [EDGE_W-1:0]      dram [256];
  logic [FEAT_W-1:0]      in_stage, out_stage;
  logic [DRAM_ADDR_W-1:0] adr_log [$];
  int cyc_count = 0;
  int wr_count = 0;
  int wait_left = -1;
  int seed = 41262;
  bit rand_ack = 1'b0;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;

  tb_clk_gen u_clk (.kernel_rst (kernel_rst), .kernel_clk (kernel_clk));

  agg_top #(.LANES (LANES), .BUF_RD_LATENCY (2)) u_agg_top (.*);

  function automatic logic [FEAT_W-1:0] fill_word(input int a, input logic [31:0] salt);
    logic [FEAT_W-1:0] w;
    for (int i = 0; i < LANES; i++) begin
      w[i*LANE_W +: LANE_W] = 32'(a) * 32'h9e3779b1 + 32'(i) * 32'h01000193 + salt;
    end
    return w;
  endfunction

  function automatic logic [EDGE_W-1:0] edge_word(input int idx);
    logic [EDGE_W-1:0] w;
    w = '0;
    w[SRC_NODE_LSB +: SRC_NODE_W] = SRC_NODE_W'(EDGES[idx][0]);
    w[DST_NODE_LSB +: DST_NODE_W] = DST_NODE_W'(EDGES[idx][1]);
    w[FIRST_FLAG_BIT]             = (EDGES[idx][2] != 0);
    w[WEIGHT_LSB +: WEIGHT_W]     = WEIGHT_W'(EDGES[idx][3]);
    return w;
  endfunction

  function automatic logic [INST_W-1:0] build_inst(input int in_s, apf, out_s, e_s, e_n);
    logic [INST_W-1:0] w;
    w = '0;
    w[INPUT_START_LSB +: INPUT_START_W]           = INPUT_START_W'(in_s);
    w[ADDR_PER_FEATURE_LSB +: ADDR_PER_FEATURE_W] = ADDR_PER_FEATURE_W'(apf);
    w[OUTPUT_START_LSB +: OUTPUT_START_W]         = OUTPUT_START_W'(out_s);
    w[EDGE_DRAM_START_LSB +: EDGE_DRAM_START_W]   = EDGE_DRAM_START_W'(e_s);
    w[EDGE_NUMBER_LSB +: EDGE_NUMBER_W]           = EDGE_NUMBER_W'(e_n);
    return w;
  endfunction

  ////////////////////////////////////////////////////////////
  // models
  ////////////////////////////////////////////////////////////
  // feature buffers are filled while reset is high
  always @(posedge kernel_rst) begin
    if (kernel_clk) begin
      for (int a = 0; a < BUF_WORDS; a++) begin
        in_mem[a]  <= fill_word(a, IN_SALT);
        out_mem[a] <= fill_word(a, OUT_SALT);
      end
    end else begin
      if (in_rd_en) in_stage <= in_mem[in_rd_addr];
      if (out_rd_en) out_stage <= out_mem[out_rd_addr];
      in_rd_data  <= in_stage;
      out_rd_data <= out_stage;
      if (out_wr_en) begin
        out_mem[out_wr_addr] <= out_wr_data;
        wr_count <= wr_count + 1;
      end
    end
  end

  // dram slave with the edges of each table row at their own place
  always @(posedge kernel_rst) begin
    if (kernel_clk) begin
      wb_ack    <= 1'b0;
      wait_left = -1;
      for (int a = 0; a < 256; a++) begin
        dram[a] <= {32'(a) * 32'h2545f491, ~(32'(a) * 32'h2545f491)};
      end
      for (int r = 0; r < NROWS; r++) begin
        for (int e = 0; e < ROW[r][4]; e++) begin
          dram[8'(ROW[r][6] + ROW[r][3] + e)] <= edge_word(ROW[r][5] + e);
        end
      end
    end else begin
      if (wb_cyc) cyc_count <= cyc_count + 1;
      if (wb_ack) begin
        wb_ack <= 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (wait_left < 0) wait_left = rand_ack ? $unsigned($random(seed)) % 4 : 0;
        if (wait_left == 0) begin
          wb_ack   <= 1'b1;
          wb_dat_i <= dram[wb_adr[7:0]];
          adr_log.push_back(wb_adr);
          check_value("wishbone we", wb_we, 1'b0);
          wait_left = -1;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // expected values and checks
  ////////////////////////////////////////////////////////////
  // each lane gets src times weight plus the old dst, or plus zero on first
  function automatic void update_expected(input int r);
    int e, k, i, src, dst, ia, oa;
    logic [FEAT_W-1:0] src_word;
    logic [LANE_W-1:0] wt, base;
    for (e = 0; e < ROW[r][4]; e++) begin
      src = EDGES[ROW[r][5] + e][0];
      dst = EDGES[ROW[r][5] + e][1];
      wt  = LANE_W'(EDGES[ROW[r][5] + e][3]);
      for (k = 0; k < ROW[r][1]; k++) begin
        ia       = (ROW[r][0] + ROW[r][1] * src + k) % BUF_WORDS;
        oa       = (ROW[r][2] + ROW[r][1] * dst + k) % BUF_WORDS;
        src_word = fill_word(ia, IN_SALT);
        for (i = 0; i < LANES; i++) begin
          base = (EDGES[ROW[r][5] + e][2] != 0) ? '0 : exp_mem[oa][i*LANE_W +: LANE_W];
          exp_mem[oa][i*LANE_W +: LANE_W] = base + src_word[i*LANE_W +: LANE_W] * wt;
        end
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [FEAT_W-1:0] got,
                             input logic [FEAT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic run_row(input int r);
    int  cyc0, wr0, adr0, n, a, e;
    bit  done;
    cyc0     = cyc_count;
    wr0      = wr_count;
    adr0     = adr_log.size();
    rand_ack = (ROW[r][7] != 0);
    update_expected(r);
    @(posedge kernel_rst);
    ap_start         <= 1'b1;
    ctrl_instruction <= build_inst(ROW[r][0], ROW[r][1], ROW[r][2], ROW[r][3], ROW[r][4]);
    ctrl_addr_offset <= DRAM_ADDR_W'(ROW[r][6]);
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge kernel_rst);
      n++;
      // a second start in mid-run, with other fields, must be ignored
      if (ROW[r][8] != 0 && n == 8) begin
        ap_start         <= 1'b1;
        ctrl_instruction <= build_inst(500, 4, 900, 40, 3);
        ctrl_addr_offset <= DRAM_ADDR_W'('h99);
      end else begin
        ap_start <= 1'b0;
      end
      @(negedge kernel_rst);
      done = ap_done;
    end
    if (!done) begin
      $display("timeout: ap_done never came for table row %0d", r);
      timeouts++;
      return;
    end
    check_value("bus word count", adr_log.size() - adr0, ROW[r][4]);
    for (e = 0; e < ROW[r][4] && adr0 + e < adr_log.size(); e++) begin
      check_value("bus address", adr_log[adr0 + e], ROW[r][6] + ROW[r][3] + e);
    end
    check_value("buffer writes", wr_count - wr0, ROW[r][4] * ROW[r][1]);
    if (ROW[r][4] == 0) begin
      check_value("bus cycles", cyc_count - cyc0, 0);
      check_value("done latency", n, 2);
    end
    if (ROW[r][8] != 0) begin
      cyc0 = cyc_count;
      repeat (20) @(negedge kernel_rst);
      check_value("bus idle after done", cyc_count - cyc0, 0);
    end
    for (a = 0; a < BUF_WORDS; a++) begin
      check_value($sformatf("row %0d output word %0d", r, a), out_mem[a], exp_mem[a]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int n, a, r, total;
    for (a = 0; a < BUF_WORDS; a++) begin
      exp_mem[a] = fill_word(a, OUT_SALT);
    end
    n = 0;
    while (kernel_clk !== 1'b0 && n < TIMEOUT) begin
      @(negedge kernel_rst);
      n++;
    end
    if (kernel_clk !== 1'b0) begin
      $display("timeout: reset was never released");
      timeouts++;
    end
    for (r = 0; r < NROWS && timeouts == 0; r++) begin
      run_row(r);
    end
    total = errors + timeouts + u_agg_top.u_props.assert_fails;
    $display("summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
             checks, errors, timeouts, u_agg_top.u_props.assert_fails);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/agg_pkg.sv
hw/edge_fetch_wb.sv
hw/agg_sequencer.sv
hw/feature_mac.sv
hw/agg_top.sv
sim/tb_clk_gen.sv
sim/agg_props.sv
sim/agg_tb.sv
